// ==== alu_block.sv ====
module alu_block #(
    parameter int NUM_REGS = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  bus_pkg::uop_t   ctl,
    input  logic            exec,
    output alu_pkg::data_t  bus,
    output alu_pkg::flags_t flags_q
);

    import alu_pkg::*;
    import bus_pkg::*;

    data_t    op_l;
    data_t    op_r;
    data_t    reg_word;
    alu_res_t alu_res;
    logic     carry_in;
    logic     reg_we;

    assign reg_we   = exec && ctl.dst_en;
    assign carry_in = ctl.use_carry && flags_q.c;  // Stored c only on request.

    reg_bank #(
        .NUM_REGS(NUM_REGS)
    ) bank0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_l   (ctl.arg_l),
        .rd_r   (ctl.arg_r),
        .rd_bus (ctl.src_reg),
        .q_l    (op_l),
        .q_r    (op_r),
        .q_bus  (reg_word),
        .we     (reg_we),
        .wr_sel (ctl.dst_reg),
        .wr_data(bus)
    );

    alu_core core0 (
        .a  (op_l),
        .b  (op_r),
        .fn (ctl.fn),
        .cin(carry_in),
        .res(alu_res)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus source mux
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        bus = '0;
        case (ctl.src)
            SRC_EXT:  bus = ctl.imm;
            SRC_REG:  bus = reg_word;
            SRC_ALU:  bus = alu_res.result;
            SRC_NONE: bus = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Flags register
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (exec && ctl.set_flags) begin
            flags_q <= alu_res.flags;  // Loads even when the bus carries another source.
        end
    end

endmodule

// ==== alu_core.sv ====
module alu_core (
    input  alu_pkg::data_t    a,
    input  alu_pkg::data_t    b,
    input  alu_pkg::alu_fn_t  fn,
    input  logic              cin,
    output alu_pkg::alu_res_t res
);

    import alu_pkg::*;

    logic [DATA_W:0] sum;  // One extra bit for carry and borrow.
    data_t           result;
    logic            carry;
    logic            ovf;

    always_comb begin
        sum    = '0;
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (fn)
            FN_ADD: begin
                sum    = {1'b0, a} + {1'b0, b} + {{DATA_W{1'b0}}, cin};
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
                // Same operand signs with a different result sign.
                ovf    = (a[SIGN_BIT] == b[SIGN_BIT]) && (result[SIGN_BIT] != a[SIGN_BIT]);
            end
            FN_SUB: begin
                sum    = {1'b0, a} - {1'b0, b} - {{DATA_W{1'b0}}, cin};
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];  // Set when the difference went negative.
                ovf    = (a[SIGN_BIT] != b[SIGN_BIT]) && (result[SIGN_BIT] != a[SIGN_BIT]);
            end
            FN_AND: begin
                result = a & b;
            end
            FN_OR: begin
                result = a | b;
            end
            FN_XOR: begin
                result = a ^ b;
            end
            FN_INC: begin
                sum    = {1'b0, a} + {{DATA_W{1'b0}}, 1'b1};
                result = sum[DATA_W-1:0];
                carry  = sum[DATA_W];
            end
            FN_SHL: begin
                result = {a[DATA_W-2:0], 1'b0};
                carry  = a[SIGN_BIT];
            end
            FN_PASS: begin
                result = a;
            end
            default: begin
                result = a;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Result and flags
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        res.result  = result;
        res.flags.n = result[SIGN_BIT];
        res.flags.z = (result == '0);
        res.flags.c = carry;
        res.flags.v = ovf;
    end

endmodule

// ==== alu_pkg.sv ====
package alu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Data word
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_W   = 8;
    localparam int SIGN_BIT = DATA_W - 1;  // Flags n and v look at this bit.

    typedef logic [DATA_W-1:0] data_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Function codes
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [2:0] alu_fn_t;

    localparam alu_fn_t FN_ADD  = 3'd0;  // Left plus right plus carry in.
    localparam alu_fn_t FN_SUB  = 3'd1;  // Left minus right minus borrow in.
    localparam alu_fn_t FN_AND  = 3'd2;
    localparam alu_fn_t FN_OR   = 3'd3;
    localparam alu_fn_t FN_XOR  = 3'd4;
    localparam alu_fn_t FN_INC  = 3'd5;  // Left plus one.
    localparam alu_fn_t FN_SHL  = 3'd6;  // Bit shifted out goes to c.
    localparam alu_fn_t FN_PASS = 3'd7;  // Left operand unchanged.

    // ~~~~~~~~~~~~~~~~~~~~
    // Flags and result
    // ~~~~~~~~~~~~~~~~~~~~

    // c holds the carry of add, inc and shl, and the borrow of sub.
    // v is only ever set by add and sub.
    typedef struct packed {
        logic n;  // Result sign bit.
        logic z;  // Result is zero.
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        data_t  result;
        flags_t flags;
    } alu_res_t;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

    typedef logic [2:0] reg_sel_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus sources
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [1:0] bus_src_t;

    localparam bus_src_t SRC_EXT  = 2'd0;  // Immediate field of the micro-operation.
    localparam bus_src_t SRC_REG  = 2'd1;  // Bank register named by src_reg.
    localparam bus_src_t SRC_ALU  = 2'd2;  // ALU result.
    localparam bus_src_t SRC_NONE = 2'd3;  // Bus reads zero.

    // ~~~~~~~~~~~~~~~~~~~~
    // Micro-operation
    // ~~~~~~~~~~~~~~~~~~~~

    // One bus transfer with an optional ALU operation and write-back.
    typedef struct packed {
        bus_src_t         src;
        reg_sel_t         src_reg;
        logic             dst_en;     // Write the bus value to dst_reg.
        reg_sel_t         dst_reg;
        reg_sel_t         arg_l;      // Left ALU operand register.
        reg_sel_t         arg_r;      // Right ALU operand register.
        alu_pkg::alu_fn_t fn;
        logic             use_carry;  // Stored c feeds add and sub.
        logic             set_flags;  // Flags register loads the ALU flags.
        alu_pkg::data_t   imm;
    } uop_t;

endpackage

// ==== datapath_top.sv ====
module datapath_top #(
    parameter int NUM_REGS = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req,
    input  bus_pkg::uop_t   uop,
    output logic            ack,
    output alu_pkg::data_t  bus_value,
    output alu_pkg::flags_t flags
);

    import alu_pkg::*;
    import bus_pkg::*;

    uop_t   ctl;
    logic   exec;
    data_t  bus;
    flags_t flags_q;

    uop_sequencer seq0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .uop      (uop),
        .ack      (ack),
        .bus_value(bus_value),
        .flags    (flags),
        .ctl      (ctl),
        .exec     (exec),
        .bus      (bus),
        .flags_q  (flags_q)
    );

    alu_block #(
        .NUM_REGS(NUM_REGS)
    ) blk0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctl    (ctl),
        .exec   (exec),
        .bus    (bus),
        .flags_q(flags_q)
    );

endmodule

// ==== reg_bank.sv ====
module reg_bank #(
    parameter int NUM_REGS = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::reg_sel_t rd_l,
    input  bus_pkg::reg_sel_t rd_r,
    input  bus_pkg::reg_sel_t rd_bus,
    output alu_pkg::data_t    q_l,
    output alu_pkg::data_t    q_r,
    output alu_pkg::data_t    q_bus,
    input  logic              we,
    input  bus_pkg::reg_sel_t wr_sel,
    input  alu_pkg::data_t    wr_data
);

    import alu_pkg::*;
    import bus_pkg::*;

    data_t regs [NUM_REGS];

    // Selects with no matching register fall through to zero.
    function automatic data_t read_word(input reg_sel_t sel);
        data_t word;
        word = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (sel == reg_sel_t'(i)) begin
                word = regs[i];
            end
        end
        return word;
    endfunction

    // A write to an index at or above NUM_REGS matches no entry.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            if (!rst_n) begin
                regs[i] <= '0;
            end else if (we && (wr_sel == reg_sel_t'(i))) begin
                regs[i] <= wr_data;
            end
        end
    end

    always_comb begin
        q_l   = read_word(rd_l);
        q_r   = read_word(rd_r);
        q_bus = read_word(rd_bus);  // Source register for SRC_REG.
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator, runs it and checks for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_datapath -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Verification passed"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// ==== tb.f ====
alu_pkg.sv
bus_pkg.sv
alu_core.sv
reg_bank.sv
alu_block.sv
uop_sequencer.sv
datapath_top.sv
tb_datapath_properties.sv
tb_datapath.sv

// ==== tb_datapath.sv ====
module tb_datapath;

    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;
    import bus_pkg::*;

    localparam int NUM_REGS   = 4;
    localparam int MAX_CYCLES = 1000;  // About 100 micro-operations of at most 6 cycles each.

    logic   clk;
    logic   rst_n;
    logic   req;
    uop_t   uop;
    logic   ack;
    data_t  bus_value;
    flags_t flags;

    integer seed   = 32'hc28bdd5a;
    int     cycles = 0;

    data_t  shadow [8];  // Reference copy of the bank. Entries at or above NUM_REGS stay zero.
    flags_t shadow_flags;

    datapath_top #(
        .NUM_REGS(NUM_REGS)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .uop      (uop),
        .ack      (ack),
        .bus_value(bus_value),
        .flags    (flags)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    task automatic report_error(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic alu_res_t alu_ref(input data_t a, input data_t b, input alu_fn_t fn,
                                         input logic cin);
        int       ua;
        int       ub;
        int       sa;
        int       sb;
        int       ci;
        int       u_sum;
        int       s_sum;
        data_t    y;
        logic     c;
        logic     v;
        alu_res_t r;
        ua = int'(a);
        ub = int'(b);
        sa = int'($signed(a));
        sb = int'($signed(b));
        ci = cin ? 1 : 0;
        y  = a;
        c  = 1'b0;
        v  = 1'b0;
        case (fn)
            FN_ADD: begin
                u_sum = ua + ub + ci;
                s_sum = sa + sb + ci;
                y     = u_sum[7:0];
                c     = (u_sum > 255);
                v     = (s_sum > 127) || (s_sum < -128);
            end
            FN_SUB: begin
                u_sum = ua - ub - ci;
                s_sum = sa - sb - ci;
                y     = u_sum[7:0];
                c     = (u_sum < 0);  // Borrow.
                v     = (s_sum > 127) || (s_sum < -128);
            end
            FN_AND: y = a & b;
            FN_OR:  y = a | b;
            FN_XOR: y = a ^ b;
            FN_INC: begin
                u_sum = ua + 1;
                y     = u_sum[7:0];
                c     = (u_sum > 255);
            end
            FN_SHL: begin
                y = {a[6:0], 1'b0};
                c = a[7];
            end
            default: y = a;
        endcase
        r.result  = y;
        r.flags.n = y[7];
        r.flags.z = (y == 8'h00);
        r.flags.c = c;
        r.flags.v = v;
        return r;
    endfunction

    function automatic data_t read_ref(input reg_sel_t sel);
        if (int'(sel) >= NUM_REGS) return 8'h00;
        return shadow[sel];
    endfunction

    task automatic model_step(input uop_t u, output data_t exp_bus, output flags_t exp_flags);
        alu_res_t r;
        r = alu_ref(read_ref(u.arg_l), read_ref(u.arg_r), u.fn, u.use_carry && shadow_flags.c);
        case (u.src)
            SRC_EXT: exp_bus = u.imm;
            SRC_REG: exp_bus = read_ref(u.src_reg);
            SRC_ALU: exp_bus = r.result;
            default: exp_bus = 8'h00;
        endcase
        if (u.dst_en && int'(u.dst_reg) < NUM_REGS) shadow[u.dst_reg] = exp_bus;
        if (u.set_flags) shadow_flags = r.flags;
        exp_flags = shadow_flags;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Driving and checking
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic uop_t load_uop(input reg_sel_t dst, input data_t value);
        uop_t u;
        u         = '0;
        u.src     = SRC_EXT;
        u.dst_en  = 1'b1;
        u.dst_reg = dst;
        u.imm     = value;
        return u;
    endfunction

    function automatic uop_t alu_uop(input alu_fn_t fn, input reg_sel_t dst, input reg_sel_t l,
                                     input reg_sel_t r, input logic carry, input logic set_fl);
        uop_t u;
        u           = '0;
        u.src       = SRC_ALU;
        u.dst_en    = 1'b1;
        u.dst_reg   = dst;
        u.arg_l     = l;
        u.arg_r     = r;
        u.fn        = fn;
        u.use_carry = carry;
        u.set_flags = set_fl;
        return u;
    endfunction

    function automatic uop_t read_uop(input reg_sel_t sel);
        uop_t u;
        u         = '0;
        u.src     = SRC_REG;
        u.src_reg = sel;
        return u;
    endfunction

    task automatic check_result(input data_t exp_bus, input flags_t exp_flags);
        assert (bus_value === exp_bus) else
            report_error($sformatf("Mismatch at %0t: bus_value %h, expected %h",
                                   $time, bus_value, exp_bus));
        assert (flags === exp_flags) else
            report_error($sformatf("Mismatch at %0t: flags nzcv %b, expected %b",
                                   $time, flags, exp_flags));
    endtask

    // Starts and ends on a falling edge with ack low.
    task automatic run_uop(input uop_t u);
        data_t  exp_bus;
        flags_t exp_flags;
        model_step(u, exp_bus, exp_flags);
        uop = u;
        req = 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        check_result(exp_bus, exp_flags);
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        req   = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 8; i++) shadow[i] = 8'h00;
        shadow_flags = '0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic load_and_add();
        run_uop(load_uop(3'd0, 8'd24));
        run_uop(load_uop(3'd1, 8'd18));
        run_uop(alu_uop(FN_ADD, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1));
        run_uop(read_uop(3'd0));  // 42 with all flags clear.
    endtask

    task automatic wrap_around();
        run_uop(load_uop(3'd1, 8'd214));
        run_uop(alu_uop(FN_ADD, 3'd0, 3'd0, 3'd1, 1'b0, 1'b1));
        run_uop(read_uop(3'd0));
        run_uop(alu_uop(FN_ADD, 3'd0, 3'd0, 3'd1, 1'b1, 1'b1));  // Carry from the wrap adds one.
    endtask

    task automatic exercise_functions();
        run_uop(load_uop(3'd2, 8'h70));
        run_uop(load_uop(3'd3, 8'h30));
        run_uop(alu_uop(FN_ADD, 3'd0, 3'd2, 3'd3, 1'b0, 1'b1));  // Positive overflow.
        run_uop(alu_uop(FN_SUB, 3'd1, 3'd3, 3'd2, 1'b1, 1'b1));
        run_uop(alu_uop(FN_SUB, 3'd1, 3'd3, 3'd2, 1'b1, 1'b1));  // Borrow in from the last sub.
        run_uop(load_uop(3'd2, 8'h80));
        run_uop(load_uop(3'd3, 8'h01));
        run_uop(alu_uop(FN_SUB, 3'd0, 3'd2, 3'd3, 1'b0, 1'b1));
        run_uop(alu_uop(FN_AND, 3'd0, 3'd2, 3'd3, 1'b0, 1'b1));
        run_uop(alu_uop(FN_OR,  3'd0, 3'd2, 3'd3, 1'b0, 1'b1));
        run_uop(alu_uop(FN_XOR, 3'd1, 3'd2, 3'd3, 1'b0, 1'b1));
        run_uop(alu_uop(FN_SHL, 3'd0, 3'd2, 3'd2, 1'b0, 1'b1));
        run_uop(load_uop(3'd3, 8'hff));
        run_uop(alu_uop(FN_INC, 3'd0, 3'd3, 3'd3, 1'b0, 1'b1));
        run_uop(alu_uop(FN_PASS, 3'd1, 3'd3, 3'd0, 1'b0, 1'b1));
        run_uop(alu_uop(FN_ADD, 3'd0, 3'd1, 3'd1, 1'b0, 1'b0));  // Flags must hold.
    endtask

    task automatic bus_sources();
        uop_t u;
        run_uop(read_uop(3'd1));
        u     = load_uop(3'd2, 8'h99);
        u.src = SRC_NONE;
        run_uop(u);
        u        = load_uop(3'd3, 8'h33);
        u.dst_en = 1'b0;
        run_uop(u);
        run_uop(read_uop(3'd3));
        for (int i = 4; i < 8; i++) begin
            run_uop(load_uop(3'(i), 8'hc3));
            run_uop(read_uop(3'(i)));
        end
        run_uop(alu_uop(FN_PASS, 3'd2, 3'd6, 3'd0, 1'b0, 1'b1));
    endtask

    task automatic random_sequence();
        logic [31:0] r;
        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            run_uop(r[27:0]);
        end
    endtask

    task automatic handshake_and_reset();
        data_t  exp_bus;
        flags_t exp_flags;
        uop_t   u;
        u           = load_uop(3'd2, 8'h5a);
        u.fn        = FN_PASS;
        u.arg_l     = 3'd7;  // Reads zero, so z is set in the flags before the reset.
        u.set_flags = 1'b1;
        model_step(u, exp_bus, exp_flags);
        uop = u;
        req = 1'b1;
        @(negedge clk);
        assert (!ack) else report_error("ack rose one edge after req was sampled");
        @(negedge clk);
        assert (ack) else report_error("ack was not high two edges after req was sampled");
        check_result(exp_bus, exp_flags);
        repeat (3) begin
            @(negedge clk);
            assert (ack) else report_error("ack dropped while req was still held");
            check_result(exp_bus, exp_flags);
        end
        req = 1'b0;
        @(negedge clk);
        assert (!ack) else report_error("ack did not fall one edge after req dropped");
        apply_reset();
        for (int i = 0; i < NUM_REGS; i++) run_uop(read_uop(3'(i)));
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        uop   = '0;
        apply_reset();
        load_and_add();
        wrap_around();
        exercise_functions();
        bus_sources();
        random_sequence();
        handshake_and_reset();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== tb_datapath_properties.sv ====
module tb_datapath_properties (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic exec
);

    timeunit 1ns;
    timeprecision 1ps;

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshake rules
    // ~~~~~~~~~~~~~~~~~~~~

    ack_rise_on_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending request");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // The write-back strobe is a single cycle.
    exec_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(exec) |=> !exec)
        else $error("exec stayed high for more than one cycle");

    ack_low_after_reset: assert property (@(posedge clk)
        !rst_n |=> !ack)
        else $error("ack was not low in the cycle after reset");

endmodule

bind uop_sequencer tb_datapath_properties props0 (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (req),
    .ack  (ack),
    .exec (exec)
);

// ==== uop_sequencer.sv ====
module uop_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req,
    input  bus_pkg::uop_t   uop,
    output logic            ack,
    output alu_pkg::data_t  bus_value,
    output alu_pkg::flags_t flags,
    output bus_pkg::uop_t   ctl,
    output logic            exec,
    input  alu_pkg::data_t  bus,
    input  alu_pkg::flags_t flags_q
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        DONE
    } state_t;

    state_t state;
    logic   accept;

    assign accept = (state == IDLE) && req;

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= DONE;
                    ack   <= 1'b1;  // Result and flags are valid from this edge on.
                end
                DONE: begin
                    if (!req) begin
                        state <= IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= IDLE;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Payload capture
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (accept) begin
            ctl <= uop;  // Held steady for the ALU block until the next request.
        end
        if (state == EXEC) begin
            bus_value <= bus;
        end
    end

    // The ALU block writes back on the single EXEC cycle.
    assign exec = (state == EXEC);

    // Flags only change on exec, so they stay stable while ack is high.
    assign flags = flags_q;

endmodule
